// ==== src/riscv_pkg.sv ====
package riscv_pkg;

  // datapath geometry
  localparam int XLEN       = 32;
  localparam int REG_ADDR_W = 5;
  localparam int NUM_REGS   = 32;

  typedef logic [XLEN-1:0]       xlen_t;      // register or alu value
  typedef logic [REG_ADDR_W-1:0] reg_addr_t;  // register index
  typedef logic [31:0]           inst_t;      // raw instruction word
  typedef logic [6:0]            opcode_t;
  typedef logic [3:0]            alu_op_t;
  typedef logic                  fwd_sel_t;   // 0 = regfile, 1 = write-back

  // major opcodes still decoded
  localparam opcode_t OPC_OP     = 7'b0110011;  // register-register
  localparam opcode_t OPC_OP_IMM = 7'b0010011;  // register-immediate
  localparam opcode_t OPC_LUI    = 7'b0110111;

  // alu operations
  localparam alu_op_t ALU_ADD    = 4'd0;
  localparam alu_op_t ALU_SUB    = 4'd1;
  localparam alu_op_t ALU_SLL    = 4'd2;
  localparam alu_op_t ALU_SLT    = 4'd3;
  localparam alu_op_t ALU_SLTU   = 4'd4;
  localparam alu_op_t ALU_XOR    = 4'd5;
  localparam alu_op_t ALU_SRL    = 4'd6;
  localparam alu_op_t ALU_SRA    = 4'd7;
  localparam alu_op_t ALU_OR     = 4'd8;
  localparam alu_op_t ALU_AND    = 4'd9;
  localparam alu_op_t ALU_PASS_B = 4'd10;  // lui result

  // operand source in execute
  localparam fwd_sel_t FWD_RF = 1'b0;
  localparam fwd_sel_t FWD_WB = 1'b1;

endpackage

// ==== src/riscv_control.sv ====
module riscv_control (
  input  riscv_pkg::inst_t     i_inst,       // instruction in decode
  input  riscv_pkg::reg_addr_t i_rs1addr_e,
  input  riscv_pkg::reg_addr_t i_rs2addr_e,
  input  riscv_pkg::reg_addr_t i_rdaddr_w,
  input  logic                 i_regw_w,
  output logic                 o_legal,
  output logic                 o_regw,
  output riscv_pkg::alu_op_t   o_alu_op,
  output logic                 o_bsel_imm,
  output logic                 o_asel_zero,
  output riscv_pkg::fwd_sel_t  o_fwd_a,
  output riscv_pkg::fwd_sel_t  o_fwd_b
);
  import riscv_pkg::*;

  opcode_t     opcode;
  logic [2:0]  funct3;
  logic [6:0]  funct7;
  logic        f7_zero;
  logic        f7_alt;    // 0100000, sub and sra

  assign opcode  = i_inst[6:0];
  assign funct3  = i_inst[14:12];
  assign funct7  = i_inst[31:25];
  assign f7_zero = (funct7 == 7'b0000000);
  assign f7_alt  = (funct7 == 7'b0100000);

  // funct3 to alu op where alt picks sub / sra
  function automatic alu_op_t f3_to_alu(input logic [2:0] f3, input logic alt);
    case (f3)
      3'b000:  return alt ? ALU_SUB : ALU_ADD;
      3'b001:  return ALU_SLL;
      3'b010:  return ALU_SLT;
      3'b011:  return ALU_SLTU;
      3'b100:  return ALU_XOR;
      3'b101:  return alt ? ALU_SRA : ALU_SRL;
      3'b110:  return ALU_OR;
      default: return ALU_AND;
    endcase
  endfunction

  always_comb begin
    o_legal     = 1'b0;
    o_alu_op    = ALU_ADD;
    o_bsel_imm  = 1'b0;
    o_asel_zero = 1'b0;
    case (opcode)
      OPC_OP: begin
        // only add/sub and srl/sra have an alternate funct7
        o_legal  = f7_zero || (f7_alt && (funct3 == 3'b000 || funct3 == 3'b101));
        o_alu_op = f3_to_alu(funct3, funct7[5]);
      end
      OPC_OP_IMM: begin
        o_bsel_imm = 1'b1;
        if (funct3 == 3'b001)
          o_legal = f7_zero;               // slli
        else if (funct3 == 3'b101)
          o_legal = f7_zero || f7_alt;     // srli / srai
        else
          o_legal = 1'b1;
        o_alu_op = f3_to_alu(funct3, funct7[5] && (funct3 == 3'b101));  // no subi
      end
      OPC_LUI: begin
        o_legal     = 1'b1;
        o_asel_zero = 1'b1;
        o_bsel_imm  = 1'b1;
        o_alu_op    = ALU_PASS_B;
      end
      default: o_legal = 1'b0;             // becomes a bubble
    endcase
  end

  // every kept instruction writes rd
  assign o_regw = o_legal;

  // write-back to execute bypass that never forwards x0
  assign o_fwd_a = (i_regw_w && i_rdaddr_w != '0 && i_rdaddr_w == i_rs1addr_e) ? FWD_WB : FWD_RF;
  assign o_fwd_b = (i_regw_w && i_rdaddr_w != '0 && i_rdaddr_w == i_rs2addr_e) ? FWD_WB : FWD_RF;

endmodule

// ==== src/riscv_regfile.sv ====
module riscv_regfile (
  input  logic                 i_riscv_clk,
  input  logic                 i_rst_n,
  input  logic                 i_we,
  input  riscv_pkg::reg_addr_t i_waddr,
  input  riscv_pkg::reg_addr_t i_raddr1,
  input  riscv_pkg::reg_addr_t i_raddr2,
  input  riscv_pkg::xlen_t     i_wdata,
  output riscv_pkg::xlen_t     o_rdata1,
  output riscv_pkg::xlen_t     o_rdata2
);
  import riscv_pkg::*;

  xlen_t regs [NUM_REGS];

  always_ff @(posedge i_riscv_clk) begin
    if (!i_rst_n) begin
      for (int i = 0; i < NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (i_we && i_waddr != '0) begin
      regs[i_waddr] <= i_wdata;
    end
  end

  // same-cycle write shows up on the read
  function automatic xlen_t read_port(input reg_addr_t addr);
    if (addr == '0)
      return '0;
    else if (i_we && i_waddr == addr)
      return i_wdata;   // write-through
    else
      return regs[addr];
  endfunction

  assign o_rdata1 = read_port(i_raddr1);
  assign o_rdata2 = read_port(i_raddr2);

endmodule

// ==== src/riscv_dstage.sv ====
module riscv_dstage (
  input  logic                 i_riscv_clk,
  input  logic                 i_rst_n,
  input  logic                 i_inst_valid,
  input  riscv_pkg::inst_t     i_inst,
  input  logic                 i_legal,
  input  logic                 i_regw,
  input  riscv_pkg::alu_op_t   i_alu_op,
  input  logic                 i_bsel_imm,
  input  logic                 i_asel_zero,
  input  logic                 i_wb_we,      // regfile write port
  input  riscv_pkg::reg_addr_t i_wb_addr,
  input  riscv_pkg::xlen_t     i_wb_data,
  output logic                 o_valid_e,
  output logic                 o_regw_e,
  output logic                 o_bsel_imm_e,
  output logic                 o_asel_zero_e,
  output riscv_pkg::alu_op_t   o_alu_op_e,
  output riscv_pkg::reg_addr_t o_rs1addr_e,
  output riscv_pkg::reg_addr_t o_rs2addr_e,
  output riscv_pkg::reg_addr_t o_rdaddr_e,
  output riscv_pkg::xlen_t     o_rs1data_e,
  output riscv_pkg::xlen_t     o_rs2data_e,
  output riscv_pkg::xlen_t     o_imm_e
);
  import riscv_pkg::*;

  reg_addr_t rs1addr;
  reg_addr_t rs2addr;
  reg_addr_t rdaddr;
  xlen_t     rs1data;
  xlen_t     rs2data;
  xlen_t     imm;

  assign rs1addr = i_inst[19:15];
  assign rs2addr = i_inst[24:20];
  assign rdaddr  = i_inst[11:7];

  // u-type for lui, i-type otherwise (shamt sits in imm[4:0])
  assign imm = (opcode_t'(i_inst[6:0]) == OPC_LUI) ? {i_inst[31:12], 12'b0}
                                                   : {{(XLEN-12){i_inst[31]}}, i_inst[31:20]};

  riscv_regfile u_riscv_regfile (
    .i_riscv_clk (i_riscv_clk),
    .i_rst_n     (i_rst_n),
    .i_we        (i_wb_we),
    .i_waddr     (i_wb_addr),
    .i_raddr1    (rs1addr),
    .i_raddr2    (rs2addr),
    .i_wdata     (i_wb_data),
    .o_rdata1    (rs1data),
    .o_rdata2    (rs2data)
  );

  // decode/execute register
  always_ff @(posedge i_riscv_clk) begin
    if (!i_rst_n) begin
      o_valid_e <= 1'b0;
    end else begin
      o_valid_e <= i_inst_valid && i_legal;  // illegal -> bubble
    end
  end

  always_ff @(posedge i_riscv_clk) begin
    o_regw_e      <= i_regw;
    o_bsel_imm_e  <= i_bsel_imm;
    o_asel_zero_e <= i_asel_zero;
    o_alu_op_e    <= i_alu_op;
    o_rs1addr_e   <= rs1addr;
    o_rs2addr_e   <= rs2addr;
    o_rdaddr_e    <= rdaddr;
    o_rs1data_e   <= rs1data;
    o_rs2data_e   <= rs2data;
    o_imm_e       <= imm;
  end

endmodule

// ==== src/riscv_estage.sv ====
module riscv_estage (
  input  logic                 i_riscv_clk,
  input  logic                 i_rst_n,
  input  logic                 i_valid_e,
  input  logic                 i_regw_e,
  input  logic                 i_bsel_imm_e,
  input  logic                 i_asel_zero_e,
  input  riscv_pkg::alu_op_t   i_alu_op_e,
  input  riscv_pkg::reg_addr_t i_rdaddr_e,
  input  riscv_pkg::xlen_t     i_rs1data_e,
  input  riscv_pkg::xlen_t     i_rs2data_e,
  input  riscv_pkg::xlen_t     i_imm_e,
  input  riscv_pkg::fwd_sel_t  i_fwd_a,
  input  riscv_pkg::fwd_sel_t  i_fwd_b,
  output logic                 o_wb_we,      // to regfile and forwarding check
  output logic                 o_wb_valid,
  output riscv_pkg::reg_addr_t o_wb_rdaddr,
  output riscv_pkg::xlen_t     o_wb_rddata
);
  import riscv_pkg::*;

  xlen_t      rs1_val;
  xlen_t      rs2_val;
  xlen_t      op_a;
  xlen_t      op_b;
  xlen_t      alu_res;
  logic [4:0] shamt;
  logic       regw_w;

  // bypass from the instruction now in write-back
  assign rs1_val = (i_fwd_a == FWD_WB) ? o_wb_rddata : i_rs1data_e;
  assign rs2_val = (i_fwd_b == FWD_WB) ? o_wb_rddata : i_rs2data_e;

  assign op_a  = i_asel_zero_e ? '0 : rs1_val;
  assign op_b  = i_bsel_imm_e ? i_imm_e : rs2_val;
  assign shamt = op_b[4:0];

  always_comb begin
    case (i_alu_op_e)
      ALU_ADD:    alu_res = op_a + op_b;
      ALU_SUB:    alu_res = op_a - op_b;
      ALU_SLL:    alu_res = op_a << shamt;
      ALU_SLT:    alu_res = {{(XLEN-1){1'b0}}, $signed(op_a) < $signed(op_b)};
      ALU_SLTU:   alu_res = {{(XLEN-1){1'b0}}, op_a < op_b};
      ALU_XOR:    alu_res = op_a ^ op_b;
      ALU_SRL:    alu_res = op_a >> shamt;
      ALU_SRA:    alu_res = xlen_t'($signed(op_a) >>> shamt);
      ALU_OR:     alu_res = op_a | op_b;
      ALU_AND:    alu_res = op_a & op_b;
      ALU_PASS_B: alu_res = op_b;
      default:    alu_res = '0;
    endcase
  end

  // execute/write-back register
  always_ff @(posedge i_riscv_clk) begin
    if (!i_rst_n) begin
      o_wb_valid <= 1'b0;
    end else begin
      o_wb_valid <= i_valid_e;
    end
  end

  always_ff @(posedge i_riscv_clk) begin
    regw_w      <= i_regw_e;
    o_wb_rdaddr <= i_rdaddr_e;
    o_wb_rddata <= alu_res;
  end

  // x0 writes are dropped inside the regfile
  assign o_wb_we = o_wb_valid && regw_w;

endmodule

// ==== src/riscv_core.sv ====
module riscv_core (
  input  logic                 i_riscv_clk,
  input  logic                 i_rst_n,
  input  logic                 i_inst_valid,
  input  riscv_pkg::inst_t     i_inst,
  output logic                 o_wb_valid,   // retirement trace
  output riscv_pkg::reg_addr_t o_wb_rdaddr,
  output riscv_pkg::xlen_t     o_wb_rddata
);
  import riscv_pkg::*;

  // decode controls
  logic      legal_d;
  logic      regw_d;
  alu_op_t   alu_op_d;
  logic      bsel_imm_d;
  logic      asel_zero_d;

  // execute stage
  logic      valid_e;
  logic      regw_e;
  logic      bsel_imm_e;
  logic      asel_zero_e;
  alu_op_t   alu_op_e;
  reg_addr_t rs1addr_e;
  reg_addr_t rs2addr_e;
  reg_addr_t rdaddr_e;
  xlen_t     rs1data_e;
  xlen_t     rs2data_e;
  xlen_t     imm_e;
  fwd_sel_t  fwd_a;
  fwd_sel_t  fwd_b;

  logic      wb_we;

  riscv_control u_riscv_control (
    .i_inst      (i_inst),
    .i_rs1addr_e (rs1addr_e),
    .i_rs2addr_e (rs2addr_e),
    .i_rdaddr_w  (o_wb_rdaddr),
    .i_regw_w    (wb_we),
    .o_legal     (legal_d),
    .o_regw      (regw_d),
    .o_alu_op    (alu_op_d),
    .o_bsel_imm  (bsel_imm_d),
    .o_asel_zero (asel_zero_d),
    .o_fwd_a     (fwd_a),
    .o_fwd_b     (fwd_b)
  );

  riscv_dstage u_riscv_dstage (
    .i_riscv_clk   (i_riscv_clk),
    .i_rst_n       (i_rst_n),
    .i_inst_valid  (i_inst_valid),
    .i_inst        (i_inst),
    .i_legal       (legal_d),
    .i_regw        (regw_d),
    .i_alu_op      (alu_op_d),
    .i_bsel_imm    (bsel_imm_d),
    .i_asel_zero   (asel_zero_d),
    .i_wb_we       (wb_we),
    .i_wb_addr     (o_wb_rdaddr),
    .i_wb_data     (o_wb_rddata),
    .o_valid_e     (valid_e),
    .o_regw_e      (regw_e),
    .o_bsel_imm_e  (bsel_imm_e),
    .o_asel_zero_e (asel_zero_e),
    .o_alu_op_e    (alu_op_e),
    .o_rs1addr_e   (rs1addr_e),
    .o_rs2addr_e   (rs2addr_e),
    .o_rdaddr_e    (rdaddr_e),
    .o_rs1data_e   (rs1data_e),
    .o_rs2data_e   (rs2data_e),
    .o_imm_e       (imm_e)
  );

  riscv_estage u_riscv_estage (
    .i_riscv_clk   (i_riscv_clk),
    .i_rst_n       (i_rst_n),
    .i_valid_e     (valid_e),
    .i_regw_e      (regw_e),
    .i_bsel_imm_e  (bsel_imm_e),
    .i_asel_zero_e (asel_zero_e),
    .i_alu_op_e    (alu_op_e),
    .i_rdaddr_e    (rdaddr_e),
    .i_rs1data_e   (rs1data_e),
    .i_rs2data_e   (rs2data_e),
    .i_imm_e       (imm_e),
    .i_fwd_a       (fwd_a),
    .i_fwd_b       (fwd_b),
    .o_wb_we       (wb_we),
    .o_wb_valid    (o_wb_valid),
    .o_wb_rdaddr   (o_wb_rdaddr),
    .o_wb_rddata   (o_wb_rddata)
  );

endmodule

// ==== test/riscv_core_tb.sv ====
module riscv_core_tb;
  import riscv_pkg::*;

  logic      clk;
  logic      rst_n;
  logic      inst_valid;
  inst_t     inst;
  logic      wb_valid;
  reg_addr_t wb_rdaddr;
  xlen_t     wb_rddata;
  int        cycle = 0;

  // instruction table with one entry per instruction word
  string     t_name[$];
  inst_t     t_inst[$];
  logic      t_ret[$];     // 0 = must never retire
  reg_addr_t t_rd[$];
  xlen_t     t_data[$];
  int        t_gap[$];     // bubbles before the entry (-1 for random 0..2)
  int        pend_idx[$];  // table index of each instruction in flight
  int        pend_cyc[$];  // cycle count when it was driven

  riscv_core dut (
    .i_riscv_clk  (clk),
    .i_rst_n      (rst_n),
    .i_inst_valid (inst_valid),
    .i_inst       (inst),
    .o_wb_valid   (wb_valid),
    .o_wb_rdaddr  (wb_rdaddr),
    .o_wb_rddata  (wb_rddata)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  always @(posedge clk) cycle <= cycle + 1;

  function automatic inst_t r_type(logic [6:0] f7, int rs2, int rs1, logic [2:0] f3, int rd);
    return {f7, 5'(rs2), 5'(rs1), f3, 5'(rd), 7'b0110011};
  endfunction

  function automatic inst_t i_type(logic [11:0] imm, int rs1, logic [2:0] f3, int rd);
    return {imm, 5'(rs1), f3, 5'(rd), 7'b0010011};
  endfunction

  task automatic add_entry(string name, inst_t w, logic ret, int rd, xlen_t data, int gap);
    t_name.push_back(name);
    t_inst.push_back(w);
    t_ret.push_back(ret);
    t_rd.push_back(reg_addr_t'(rd));
    t_data.push_back(data);
    t_gap.push_back(gap);
  endtask

  task automatic abort_run(string why);
    $display("Test FAILED");
    $fatal(1, "%s", why);
  endtask

  task automatic check_value(string name, xlen_t exp, xlen_t act);
    if (exp !== act) begin
      $display("ERROR %s: expected 0x%08h, actual 0x%08h", name, exp, act);
      abort_run("trace port mismatch");
    end
  endtask

  // trace port is stable by the falling edge
  always @(negedge clk) begin
    int i;
    if (rst_n && wb_valid) begin
      if (pend_idx.size() == 0) begin
        abort_run("an instruction retired while none was in flight");
      end else begin
        i = pend_idx.pop_front();
        check_value({t_name[i], " latency"}, 32'd2, xlen_t'(cycle - pend_cyc.pop_front()));
        check_value({t_name[i], " rd"}, xlen_t'(t_rd[i]), xlen_t'(wb_rdaddr));
        check_value({t_name[i], " data"}, t_data[i], wb_rddata);
      end
    end
  end

  initial begin
    int    gap;
    string pre;
    void'($urandom(69));
    rst_n      = 1'b0;
    inst_valid = 1'b0;
    inst       = '0;
    add_entry("addi_neg", i_type(12'hffb, 0, 3'b000, 1), 1'b1, 1, 32'hffff_fffb, -1);
    add_entry("lui", 32'h1234_5137, 1'b1, 2, 32'h1234_5000, -1);  // lui x2, 0x12345
    add_entry("ori", i_type(12'h0f0, 2, 3'b110, 3), 1'b1, 3, 32'h1234_50f0, -1);
    add_entry("xori", i_type(12'h7ff, 1, 3'b100, 4), 1'b1, 4, 32'hffff_f804, -1);
    add_entry("andi", i_type(12'h0ff, 3, 3'b111, 5), 1'b1, 5, 32'h0000_00f0, -1);
    add_entry("slti", i_type(12'h001, 1, 3'b010, 6), 1'b1, 6, 32'h0000_0001, -1);
    add_entry("sltiu", i_type(12'h001, 1, 3'b011, 7), 1'b1, 7, 32'h0000_0000, -1);
    add_entry("addi_3", i_type(12'h003, 0, 3'b000, 8), 1'b1, 8, 32'h0000_0003, -1);
    add_entry("srai", i_type(12'h401, 1, 3'b101, 20), 1'b1, 20, 32'hffff_fffd, -1);
    // register-register ops on x1 = -5 and x8 = 3
    add_entry("add", r_type(7'h00, 8, 1, 3'b000, 9), 1'b1, 9, 32'hffff_fffe, -1);
    add_entry("sub", r_type(7'h20, 1, 8, 3'b000, 10), 1'b1, 10, 32'h0000_0008, -1);
    add_entry("sll", r_type(7'h00, 8, 8, 3'b001, 11), 1'b1, 11, 32'h0000_0018, -1);
    add_entry("srl", r_type(7'h00, 8, 1, 3'b101, 12), 1'b1, 12, 32'h1fff_ffff, -1);
    add_entry("sra", r_type(7'h20, 8, 1, 3'b101, 13), 1'b1, 13, 32'hffff_ffff, -1);
    add_entry("slt", r_type(7'h00, 8, 1, 3'b010, 14), 1'b1, 14, 32'h0000_0001, -1);
    add_entry("sltu", r_type(7'h00, 8, 1, 3'b011, 15), 1'b1, 15, 32'h0000_0000, -1);
    add_entry("and", r_type(7'h00, 3, 4, 3'b111, 16), 1'b1, 16, 32'h1234_5000, -1);
    add_entry("or", r_type(7'h00, 8, 5, 3'b110, 17), 1'b1, 17, 32'h0000_00f3, -1);
    add_entry("xor", r_type(7'h00, 3, 2, 3'b100, 18), 1'b1, 18, 32'h0000_00f0, -1);
    // same chain back to back and then spaced out
    for (int g = 0; g <= 2; g += 2) begin
      pre = (g == 0) ? "fwd_" : "spaced_";
      add_entry({pre, "addi"}, i_type(12'h007, 0, 3'b000, 22), 1'b1, 22, 32'd7, g);
      add_entry({pre, "add"}, r_type(7'h00, 22, 22, 3'b000, 23), 1'b1, 23, 32'd14, g);
      add_entry({pre, "sub"}, r_type(7'h20, 22, 23, 3'b000, 24), 1'b1, 24, 32'd7, g);
      add_entry({pre, "xor"}, r_type(7'h00, 24, 23, 3'b100, 25), 1'b1, 25, 32'd9, g);
      add_entry({pre, "add3"}, r_type(7'h00, 22, 25, 3'b000, 26), 1'b1, 26, 32'd16, g);
    end
    add_entry("addi_x0", i_type(12'h005, 8, 3'b000, 0), 1'b1, 0, 32'd8, -1);
    add_entry("read_x0", r_type(7'h00, 8, 0, 3'b000, 27), 1'b1, 27, 32'd3, 0);
    add_entry("bad_opcode", 32'h0000_007f, 1'b0, 0, 32'd0, -1);
    add_entry("mul", r_type(7'h01, 8, 8, 3'b000, 29), 1'b0, 29, 32'd0, 0);  // no m extension
    add_entry("after_bad", i_type(12'h001, 29, 3'b000, 28), 1'b1, 28, 32'd1, 0);

    repeat (10) @(posedge clk);
    #1 rst_n = 1'b1;
    repeat (3) @(posedge clk);  // trace must stay quiet while idle
    for (int i = 0; i < t_inst.size(); i++) begin
      gap = (t_gap[i] < 0) ? int'($urandom_range(2, 0)) : t_gap[i];
      repeat (gap) begin
        @(posedge clk);
        #1 inst_valid = 1'b0;
      end
      @(posedge clk);
      #1 inst_valid = 1'b1;
      inst = t_inst[i];
      if (t_ret[i]) begin
        pend_idx.push_back(i);
        pend_cyc.push_back(cycle);
      end
    end
    @(posedge clk);
    #1 inst_valid = 1'b0;
    repeat (4) @(posedge clk);  // drain the pipeline
    if (pend_idx.size() != 0) begin
      abort_run("instructions were accepted but never retired");
    end else begin
      $display("Test OK");
      $finish;
    end
  end

  // watchdog starts once the table is filled
  initial begin
    #1;
    repeat (10 + 6 * t_inst.size()) @(posedge clk);
    abort_run("timeout, the run did not finish in time");
  end

endmodule

// ==== all.f ====
src/riscv_pkg.sv
src/riscv_control.sv
src/riscv_regfile.sv
src/riscv_dstage.sv
src/riscv_estage.sv
src/riscv_core.sv
test/riscv_core_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"
rm -rf obj_dir
verilator --binary --timing -f all.f --top-module riscv_core_tb
./obj_dir/Vriscv_core_tb | tee sim.log
if grep -qx "Test OK" sim.log; then
  echo "simulation passed"
else
  echo "simulation failed"
  exit 1
fi
